// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN      = 32;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;

    // major opcodes taken by this slice
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } alu_op_e;

    typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

    // four is the link offset for jal/jalr
    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

    typedef enum logic {CTRL_RUN, CTRL_SHIFT} ctrl_state_e;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm11_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm4_0;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                 imm12;
        logic [5:0]           imm10_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm4_1;
        logic                 imm11;
        logic [6:0]           opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]          imm31_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                 imm20;
        logic [9:0]           imm10_1;
        logic                 imm11;
        logic [7:0]           imm19_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } j_fmt_t;

    // one instruction word, viewed per format
    typedef union packed {
        logic [ILEN-1:0] raw;
        r_fmt_t          r;
        i_fmt_t          i;
        s_fmt_t          s;
        b_fmt_t          b;
        u_fmt_t          u;
        j_fmt_t          j;
    } instr_u;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        instr_u               instr;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        alu_op_e              alu_op;
        src1_sel_e            src1_sel;
        src2_sel_e            src2_sel;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 is_brc;
        logic [2:0]           funct3;
        logic                 wb_en;
        logic [REG_IDX_W-1:0] rd;
        logic                 valid;
    } dec_op_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
        logic                 wb_en;
    } wb_rec_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redir_t;

endpackage

`default_nettype wire

// File: decode/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    input  logic            fire_i,
    output dec_op_t         op_o
);

    logic legal;
    logic writes_rd;

    // funct3 to alu op, alt selects sub / sra
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000: op = alt ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        op_o          = '0;
        op_o.pc       = pc_i;
        op_o.instr    = instr_i;
        op_o.rs1_val  = rs1_val_i;
        op_o.rs2_val  = rs2_val_i;
        op_o.funct3   = instr_i.r.funct3;
        op_o.rd       = instr_i.r.rd;
        op_o.alu_op   = ALU_ADD;
        op_o.src1_sel = SRC1_RS1;
        op_o.src2_sel = SRC2_IMM;
        legal         = 1'b1;
        writes_rd     = 1'b1;
        case (instr_i.r.opcode)
            OPC_LUI: begin
                op_o.imm    = {instr_i.u.imm31_12, 12'b0};
                op_o.alu_op = ALU_PASSB;
            end
            OPC_AUIPC: begin
                op_o.imm      = {instr_i.u.imm31_12, 12'b0};
                op_o.src1_sel = SRC1_PC;
            end
            OPC_JAL: begin
                op_o.imm      = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                                 instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
                op_o.src1_sel = SRC1_PC;
                op_o.src2_sel = SRC2_FOUR;
                op_o.is_jal   = 1'b1;
            end
            OPC_JALR: begin
                op_o.imm      = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                op_o.src1_sel = SRC1_PC;
                op_o.src2_sel = SRC2_FOUR;
                op_o.is_jalr  = 1'b1;
                legal         = (instr_i.i.funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                op_o.imm    = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                               instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                op_o.is_brc = 1'b1;
                writes_rd   = 1'b0;
                // 010 and 011 are unused branch codes
                legal       = (instr_i.b.funct3[2:1] != 2'b01);
            end
            OPC_OPIMM: begin
                op_o.imm    = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                op_o.alu_op = f3_to_alu(instr_i.i.funct3,
                                        instr_i.i.funct3 == 3'b101 && instr_i.r.funct7[5]);
                if (instr_i.i.funct3 == 3'b001) begin
                    legal = (instr_i.r.funct7 == F7_BASE);
                end else if (instr_i.i.funct3 == 3'b101) begin
                    legal = (instr_i.r.funct7 == F7_BASE) || (instr_i.r.funct7 == F7_ALT);
                end
            end
            OPC_OP: begin
                op_o.src2_sel = SRC2_RS2;
                op_o.alu_op   = f3_to_alu(instr_i.r.funct3, instr_i.r.funct7[5]);
                legal         = (instr_i.r.funct7 == F7_BASE) ||
                                (instr_i.r.funct7 == F7_ALT &&
                                 (instr_i.r.funct3 == 3'b000 || instr_i.r.funct3 == 3'b101));
            end
            default: begin
                legal     = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
        op_o.valid = fire_i & legal;
        op_o.wb_en = fire_i & legal & writes_rd;
    end

endmodule

`default_nettype wire

// File: logic/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  dec_op_t op_i,
    input  logic    hold_i,
    input  logic    flush_i,
    output dec_op_t op_o
);

    dec_op_t bubble;

    // bubble keeps the payload but can never retire
    always_comb begin
        bubble       = op_i;
        bubble.valid = 1'b0;
        bubble.wb_en = 1'b0;
        bubble.pc    = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_o <= '0;
        end else if (flush_i) begin
            // squash whatever is being accepted behind a redirect
            op_o <= bubble;
        end else if (!hold_i) begin
            op_o <= op_i.valid ? op_i : bubble;
        end
    end

endmodule

`default_nettype wire

// File: execute/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  dec_op_t            op_i,
    input  logic               shift_load_i,
    input  logic               shift_step_i,
    input  logic               res_load_i,
    output logic               is_shift_o,
    output logic [SHAMT_W-1:0] shamt_o,
    output redir_t             redirect_o,
    output wb_rec_t            result_o,
    output logic               result_valid_o
);

    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] shift_q;
    logic [XLEN-1:0] shift_src;
    logic [XLEN-1:0] shift_nxt;
    logic [XLEN-1:0] jalr_sum;
    logic            brc_taken;

    assign opa = (op_i.src1_sel == SRC1_PC) ? op_i.pc : op_i.rs1_val;

    always_comb begin
        case (op_i.src2_sel)
            SRC2_RS2:  opb = op_i.rs2_val;
            SRC2_FOUR: opb = XLEN'(4);
            default:   opb = op_i.imm;
        endcase
    end

    assign is_shift_o = op_i.valid & (op_i.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA});
    assign shamt_o    = opb[SHAMT_W-1:0];

    // serial shifter, on load it starts straight from operand a
    assign shift_src = shift_load_i ? opa : shift_q;

    always_comb begin
        case (op_i.alu_op)
            ALU_SLL: shift_nxt = {shift_src[XLEN-2:0], 1'b0};
            ALU_SRA: shift_nxt = {shift_src[XLEN-1], shift_src[XLEN-1:1]};
            default: shift_nxt = {1'b0, shift_src[XLEN-1:1]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (shift_step_i) begin
            shift_q <= shift_nxt;
        end else if (shift_load_i) begin
            shift_q <= opa;
        end
    end

    always_comb begin
        case (op_i.alu_op)
            ALU_ADD:   alu_res = opa + opb;
            ALU_SUB:   alu_res = opa - opb;
            ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU:  alu_res = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_XOR:   alu_res = opa ^ opb;
            ALU_OR:    alu_res = opa | opb;
            ALU_AND:   alu_res = opa & opb;
            ALU_PASSB: alu_res = opb;
            // shifts leave through the serial path
            default:   alu_res = shift_src;
        endcase
    end

    always_comb begin
        case (op_i.funct3)
            3'b000:  brc_taken = (op_i.rs1_val == op_i.rs2_val);
            3'b001:  brc_taken = (op_i.rs1_val != op_i.rs2_val);
            3'b100:  brc_taken = ($signed(op_i.rs1_val) < $signed(op_i.rs2_val));
            3'b101:  brc_taken = ($signed(op_i.rs1_val) >= $signed(op_i.rs2_val));
            3'b110:  brc_taken = (op_i.rs1_val < op_i.rs2_val);
            default: brc_taken = (op_i.rs1_val >= op_i.rs2_val);
        endcase
    end

    assign jalr_sum = op_i.rs1_val + op_i.imm;

    always_comb begin
        redirect_o.taken  = op_i.valid &
                            (op_i.is_jal | op_i.is_jalr | (op_i.is_brc & brc_taken));
        redirect_o.target = op_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : op_i.pc + op_i.imm;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= res_load_i & op_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_load_i) begin
            result_o.pc    <= op_i.pc;
            result_o.rd    <= op_i.rd;
            result_o.data  <= alu_res;
            result_o.wb_en <= op_i.wb_en;
        end
    end

endmodule

`default_nettype wire

// File: logic/ex_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl_fsm
    import rv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic is_shift_i,
    input  logic cnt_done_i,
    output logic hold_o,
    output logic ready_o,
    output logic shift_load_o,
    output logic shift_step_o,
    output logic res_load_o,
    output logic cnt_load_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTRL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        hold_o       = 1'b0;
        shift_load_o = 1'b0;
        shift_step_o = 1'b0;
        res_load_o   = 1'b0;
        cnt_load_o   = 1'b0;
        case (state_q)
            CTRL_RUN: begin
                if (is_shift_i) begin
                    shift_load_o = 1'b1;
                    cnt_load_o   = 1'b1;
                    if (cnt_done_i) begin
                        // zero amount retires like any alu op
                        res_load_o = 1'b1;
                    end else begin
                        // first bit is shifted together with the load
                        shift_step_o = 1'b1;
                        hold_o       = 1'b1;
                        state_d      = CTRL_SHIFT;
                    end
                end else begin
                    res_load_o = 1'b1;
                end
            end
            default: begin
                if (cnt_done_i) begin
                    res_load_o = 1'b1;
                    state_d    = CTRL_RUN;
                end else begin
                    hold_o       = 1'b1;
                    shift_step_o = 1'b1;
                end
            end
        endcase
    end

    assign ready_o = ~hold_o;

endmodule

`default_nettype wire

// File: logic/shift_counter.sv
`timescale 1ns/1ps
`default_nettype none

module shift_counter
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_i,
    input  logic [SHAMT_W-1:0] amount_i,
    input  logic               step_i,
    output logic               done_o
);

    logic [SHAMT_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (load_i) begin
            // a step on the load cycle counts too
            count_q <= amount_i - SHAMT_W'(step_i);
        end else if (step_i) begin
            count_q <= count_q - SHAMT_W'(1);
        end
    end

    // a fresh amount of zero is done at once
    assign done_o = load_i ? (amount_i == '0) : (count_q == '0);

endmodule

`default_nettype wire

// File: logic/ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  logic [ILEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    output logic            ready_o,
    output wb_rec_t         result_o,
    output logic            result_valid_o,
    output redir_t          redirect_o
);

    instr_u             instr_w;
    dec_op_t            dec_op;
    dec_op_t            ex_op;
    logic               fire;
    logic               hold;
    logic               is_shift;
    logic [SHAMT_W-1:0] shamt;
    logic               shift_load;
    logic               shift_step;
    logic               res_load;
    logic               cnt_load;
    logic               cnt_done;

    assign instr_w = instr_i;
    assign fire    = valid_i & ready_o;

    rv_decoder u_decoder (
        .instr_i   (instr_w),
        .pc_i      (pc_i),
        .rs1_val_i (rs1_val_i),
        .rs2_val_i (rs2_val_i),
        .fire_i    (fire),
        .op_o      (dec_op)
    );

    // a taken redirect squashes the op entering behind it
    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .op_i    (dec_op),
        .hold_i  (hold),
        .flush_i (redirect_o.taken),
        .op_o    (ex_op)
    );

    ex_alu u_alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_i           (ex_op),
        .shift_load_i   (shift_load),
        .shift_step_i   (shift_step),
        .res_load_i     (res_load),
        .is_shift_o     (is_shift),
        .shamt_o        (shamt),
        .redirect_o     (redirect_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    ex_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .is_shift_i   (is_shift),
        .cnt_done_i   (cnt_done),
        .hold_o       (hold),
        .ready_o      (ready_o),
        .shift_load_o (shift_load),
        .shift_step_o (shift_step),
        .res_load_o   (res_load),
        .cnt_load_o   (cnt_load)
    );

    shift_counter u_shift_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (cnt_load),
        .amount_i (shamt),
        .step_i   (shift_step),
        .done_o   (cnt_done)
    );

endmodule

`default_nettype wire

// File: bench/ex_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_props
    import rv_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input ctrl_state_e     state_i,
    input logic            cnt_done_i,
    input logic            ready_i,
    input logic            result_valid_i,
    input logic [XLEN-1:0] result_pc_i
);

    // SHIFT with bits still to go must stall and show no result
    a_shift_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == CTRL_SHIFT && !cnt_done_i) |-> (!ready_i && !result_valid_i))
        else $error("ready or result valid while shifting");

    // back to back results always belong to different instructions
    a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid_i && $past(result_valid_i)) |-> (result_pc_i != $past(result_pc_i)))
        else $error("same result presented twice");

    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid_i)
        else $error("result valid right after reset");

endmodule

bind ex_stage_top ex_stage_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .state_i        (u_ctrl.state_q),
    .cnt_done_i     (cnt_done),
    .ready_i        (ready_o),
    .result_valid_i (result_valid_o),
    .result_pc_i    (result_o.pc)
);

`default_nettype wire

// File: bench/ex_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_checker
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    input  logic            ready_i,
    input  wb_rec_t         result_i,
    input  logic            result_valid_i,
    input  redir_t          redirect_i,
    output int              err_count_o,
    output int              pending_o
);

    wb_rec_t         exp_q[$];
    int              due_q[$];
    int              cyc;
    int              busy_from;
    int              busy_to;
    logic            exp_taken;
    logic [XLEN-1:0] exp_target;
    logic            m_legal;
    logic            m_wr;
    logic [XLEN-1:0] m_data;
    logic            m_taken;
    logic [XLEN-1:0] m_target;
    logic            m_shift;
    int              m_shamt;
    wb_rec_t         exp_rec;

    task automatic log_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count_o++;
    endtask

    // reference behavior of one instruction, straight from the RV32I rules
    function automatic void model_instr(input instr_u w, input logic [XLEN-1:0] pc,
                                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                        output logic legal, output logic wr,
                                        output logic [XLEN-1:0] data, output logic taken,
                                        output logic [XLEN-1:0] target, output logic shift,
                                        output int shamt);
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] opb;
        logic [2:0]      f3;
        logic [6:0]      f7;
        imm_i  = {{20{w.i.imm[11]}}, w.i.imm};
        imm_u  = {w.u.imm31_12, 12'h000};
        imm_b  = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
        imm_j  = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
        f3     = w.r.funct3;
        f7     = w.r.funct7;
        legal  = 1'b1;
        wr     = 1'b1;
        data   = '0;
        taken  = 1'b0;
        target = '0;
        shift  = 1'b0;
        shamt  = 0;
        case (w.r.opcode)
            OPC_LUI:   data = imm_u;
            OPC_AUIPC: data = pc + imm_u;
            OPC_JAL: begin
                data   = pc + 32'd4;
                taken  = 1'b1;
                target = pc + imm_j;
            end
            OPC_JALR: begin
                legal  = (f3 == 3'd0);
                data   = pc + 32'd4;
                taken  = 1'b1;
                target = (a + imm_i) & ~32'h1;
            end
            OPC_BRANCH: begin
                wr     = 1'b0;
                legal  = (f3 != 3'd2) && (f3 != 3'd3);
                target = pc + imm_b;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
            end
            OPC_OP, OPC_OPIMM: begin
                opb = (w.r.opcode == OPC_OP) ? b : imm_i;
                if (w.r.opcode == OPC_OP) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                case (f3)
                    3'd0: data = (w.r.opcode == OPC_OP && f7[5]) ? a - opb : a + opb;
                    3'd1: data = a << opb[4:0];
                    3'd2: data = {31'b0, $signed(a) < $signed(opb)};
                    3'd3: data = {31'b0, a < opb};
                    3'd4: data = a ^ opb;
                    3'd5: data = f7[5] ? XLEN'($signed(a) >>> opb[4:0]) : a >> opb[4:0];
                    3'd6: data = a | opb;
                    default: data = a & opb;
                endcase
                shift = (f3 == 3'd1) || (f3 == 3'd5);
                shamt = int'(opb[4:0]);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            wr    = 1'b0;
            taken = 1'b0;
            shift = 1'b0;
        end
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q.delete();
            due_q.delete();
            cyc         = 0;
            busy_from   = 0;
            busy_to     = -1;
            exp_taken   = 1'b0;
            exp_target  = '0;
            err_count_o = 0;
            pending_o   = 0;
        end else begin
            if (redirect_i.taken !== exp_taken ||
                (exp_taken && redirect_i.target !== exp_target)) begin
                log_error($sformatf("redirect %0b/%h, expected %0b/%h", redirect_i.taken,
                                    redirect_i.target, exp_taken, exp_target));
            end
            if (ready_i && cyc >= busy_from && cyc <= busy_to) begin
                log_error("ready_o high while a shift is running");
            end
            if (result_valid_i) begin
                if (exp_q.size() == 0) begin
                    log_error($sformatf("unexpected result for pc %h", result_i.pc));
                end else begin
                    exp_rec = exp_q.pop_front();
                    if (result_i.pc !== exp_rec.pc || result_i.rd !== exp_rec.rd ||
                        result_i.wb_en !== exp_rec.wb_en ||
                        (exp_rec.wb_en && result_i.data !== exp_rec.data)) begin
                        log_error($sformatf(
                            "result pc %h rd %0d data %h wb %0b, expected %h %0d %h %0b",
                            result_i.pc, result_i.rd, result_i.data, result_i.wb_en,
                            exp_rec.pc, exp_rec.rd, exp_rec.data, exp_rec.wb_en));
                    end
                    if (cyc != due_q[0]) begin
                        log_error($sformatf("result for pc %h in cycle %0d, expected %0d",
                                            exp_rec.pc, cyc, due_q[0]));
                    end
                    void'(due_q.pop_front());
                end
            end else if (due_q.size() > 0 && cyc > due_q[0]) begin
                log_error($sformatf("missing result for pc %h", exp_q[0].pc));
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            exp_taken = 1'b0;
            // an accepted op behind a taken redirect is squashed
            if (valid_i && ready_i && !redirect_i.taken) begin
                model_instr(instr_i, pc_i, rs1_val_i, rs2_val_i, m_legal, m_wr, m_data,
                            m_taken, m_target, m_shift, m_shamt);
                if (m_legal) begin
                    exp_rec.pc    = pc_i;
                    exp_rec.rd    = instr_i.r.rd;
                    exp_rec.data  = m_data;
                    exp_rec.wb_en = m_wr;
                    exp_q.push_back(exp_rec);
                    due_q.push_back(cyc + (m_shift ? m_shamt + 1 : 1) + 1);
                    exp_taken  = m_taken;
                    exp_target = m_target;
                    if (m_shift && m_shamt > 0) begin
                        busy_from = cyc + 1;
                        busy_to   = cyc + m_shamt;
                    end
                end
            end
            cyc++;
            pending_o = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
    import rv_pkg::*;
;

    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT   = 64;

    logic            clk;
    logic            rst_n;
    logic            valid_i;
    logic [ILEN-1:0] instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] rs1_val_i;
    logic [XLEN-1:0] rs2_val_i;
    logic            ready_o;
    wb_rec_t         result_o;
    logic            result_valid_o;
    redir_t          redirect_o;
    int              chk_errors;
    int              pending;
    int              bench_errors;
    logic [XLEN-1:0] next_pc;

    ex_stage_top dut (.*);

    ex_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .rs1_val_i      (rs1_val_i),
        .rs2_val_i      (rs2_val_i),
        .ready_i        (ready_o),
        .result_i       (result_o),
        .result_valid_i (result_valid_o),
        .redirect_i     (redirect_o),
        .err_count_o    (chk_errors),
        .pending_o      (pending)
    );

    always #50 clk = ~clk;

    // mix of alu, immediate, upper, branch, jump and out-of-slice words
    function automatic logic [ILEN-1:0] random_instr();
        logic [ILEN-1:0] w;
        logic [2:0]      f3;
        int              kind;
        w    = $urandom;
        kind = $urandom_range(0, 8);
        f3   = w[14:12];
        case (kind)
            0: begin
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? F7_ALT : F7_BASE;
                w[6:0]   = OPC_OP;
            end
            1: begin
                if (f3 == 3'd1) begin
                    w[31:25] = F7_BASE;
                end else if (f3 == 3'd5) begin
                    w[31:25] = w[30] ? F7_ALT : F7_BASE;
                end
                w[6:0] = OPC_OPIMM;
            end
            2: w[6:0] = OPC_LUI;
            3: w[6:0] = OPC_AUIPC;
            4, 5: begin
                // 010 and 011 moved onto bltu / bgeu
                if (f3[2:1] == 2'b01) begin
                    w[14] = 1'b1;
                end
                w[6:0] = OPC_BRANCH;
            end
            6: w[6:0] = OPC_JAL;
            7: begin
                w[14:12] = 3'b000;
                w[6:0]   = OPC_JALR;
            end
            default: w[6:0] = 7'b0000011;
        endcase
        return w;
    endfunction

    task automatic issue_instr();
        logic [XLEN-1:0] rs1_val;
        int              cnt;
        rs1_val = $urandom;
        valid_i   <= 1'b1;
        instr_i   <= random_instr();
        pc_i      <= next_pc;
        rs1_val_i <= rs1_val;
        // equal operands now and then so that beq / bne go both ways
        rs2_val_i <= ($urandom_range(0, 3) == 0) ? rs1_val : $urandom;
        next_pc = next_pc + 32'd4;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!ready_o && cnt < TIMEOUT);
        if (!ready_o) begin
            $display("timeout: ready_o stayed low for %0d cycles", TIMEOUT);
            bench_errors++;
        end
    endtask

    task automatic drain_results();
        int cnt;
        cnt = 0;
        while (pending != 0 && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results never appeared on result_valid_o", pending);
            bench_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h00e35e1e));
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid_i      = 1'b0;
        instr_i      = '0;
        pc_i         = '0;
        rs1_val_i    = '0;
        rs2_val_i    = '0;
        bench_errors = 0;
        next_pc      = 32'h0000_1000;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if ($urandom_range(0, 4) == 0) begin
                valid_i <= 1'b0;
                repeat ($urandom_range(1, 3)) @(posedge clk);
            end
            issue_instr();
        end
        valid_i <= 1'b0;
        @(posedge clk);
        drain_results();
        repeat (2) @(posedge clk);
        $display("errors: checker %0d, bench %0d", chk_errors, bench_errors);
        if (chk_errors == 0 && bench_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/rv_pkg.sv
decode/rv_decoder.sv
logic/id_ex_reg.sv
execute/ex_alu.sv
logic/ex_ctrl_fsm.sv
logic/shift_counter.sv
logic/ex_stage_top.sv
bench/ex_stage_props.sv
bench/ex_checker.sv
bench/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ex_stage
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert
LINT_TOP  := ex_stage_top
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(LINT_TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
